// File: design/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_ctrl
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic         sysclk,
  input  logic         rst_n,
  // CPU port
  input  logic         cpu_valid,
  output logic         cpu_ready,
  input  logic         cpu_we,
  input  word_addr_t   cpu_addr,
  input  data_word_t   cpu_wdata,
  output logic         cpu_rvalid,
  output data_word_t   cpu_rdata,
  output logic         cpu_hit,
  input  logic         cache_enable,  // Low means bypass reads, no updates
  // Cache store
  output logic         st_en,
  output logic         st_we_data,
  output logic         st_set_used,
  output logic         st_clr_used,
  output cache_index_t st_index,
  output cache_tag_t   st_tag,
  output data_word_t   st_wdata,
  input  data_word_t   st_rdata,
  input  logic         st_hit,
  input  logic         clear_busy,
  // Invalidation from the DMA port
  input  logic         inv_valid,
  output logic         inv_ready,
  input  word_addr_t   inv_addr,
  // Memory master 0
  output logic         m0_valid,
  input  logic         m0_ready,
  output logic         m0_we,
  output word_addr_t   m0_addr,
  output data_word_t   m0_wdata,
  input  logic         m0_rvalid,
  input  data_word_t   m0_rdata
);

  ctrl_state_t state_q, state_d;
  logic        sent_q;       // Memory read accepted, waiting for data

  word_addr_t  req_addr_q;   // CPU or invalidation address
  data_word_t  req_wdata_q;  // Write data, reused for the fill word
  logic        req_we_q;
  logic        req_inv_q;    // Request came from the DMA snoop
  logic        en_q;         // cache_enable sampled at acceptance

  logic        hit_rd;       // Read answered from the cache
  logic        wr_hit;       // Write updates the cached word
  logic        inv_hit;      // Snooped address is cached
  logic        rd_done;      // Memory read data for the CPU

  assign inv_ready = (state_q == ctrl_idle) && !clear_busy;
  assign cpu_ready = inv_ready && !inv_valid;  // Snoops go first

  assign hit_rd  = (state_q == ctrl_compare) && !req_inv_q && !req_we_q && en_q && st_hit;
  assign wr_hit  = (state_q == ctrl_compare) && !req_inv_q && req_we_q && en_q && st_hit;
  assign inv_hit = (state_q == ctrl_compare) && req_inv_q && st_hit;
  assign rd_done = (state_q == ctrl_mem_read) && sent_q && m0_rvalid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ctrl_idle: begin
        if (inv_valid && inv_ready) begin
          state_d = ctrl_invalidate;
        end else if (cpu_valid && cpu_ready) begin
          state_d = ctrl_lookup;
        end
      end
      ctrl_lookup,
      ctrl_invalidate: state_d = ctrl_compare;  // Store answers next cycle
      ctrl_compare: begin
        if (req_inv_q || hit_rd) begin
          state_d = ctrl_idle;
        end else if (req_we_q) begin
          state_d = ctrl_mem_write;
        end else begin
          state_d = ctrl_mem_read;  // Miss or bypass
        end
      end
      ctrl_mem_read: begin
        if (rd_done) begin
          state_d = en_q ? ctrl_fill : ctrl_idle;  // No fill while disabled
        end
      end
      ctrl_fill: state_d = ctrl_idle;
      ctrl_mem_write: begin
        if (m0_ready) begin
          state_d = ctrl_idle;  // Write done on acceptance
        end
      end
      default: state_d = ctrl_idle;
    endcase
  end

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      state_q <= ctrl_idle;
      sent_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if ((state_q == ctrl_mem_read) && !sent_q && m0_ready) begin
        sent_q <= 1'b1;
      end else if (rd_done) begin
        sent_q <= 1'b0;
      end
    end
  end

  // Request capture
  always_ff @(posedge sysclk) begin
    if (inv_valid && inv_ready) begin
      req_addr_q <= inv_addr;
      req_inv_q  <= 1'b1;
      req_we_q   <= 1'b0;
    end else if (cpu_valid && cpu_ready) begin
      req_addr_q  <= cpu_addr;
      req_wdata_q <= cpu_wdata;
      req_we_q    <= cpu_we;
      req_inv_q   <= 1'b0;
      en_q        <= cache_enable;
    end else if (rd_done) begin
      req_wdata_q <= m0_rdata;  // Word for the fill
    end
  end

  // Store access
  assign st_en       = (state_q == ctrl_lookup) || (state_q == ctrl_invalidate) ||
                       wr_hit || inv_hit || (state_q == ctrl_fill);
  assign st_we_data  = wr_hit || (state_q == ctrl_fill);
  assign st_set_used = (state_q == ctrl_fill);
  assign st_clr_used = inv_hit;
  assign st_index    = req_addr_q[`CACHE_INDEX_W-1:0];
  assign st_tag      = req_addr_q[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
  assign st_wdata    = req_wdata_q;

  // Memory side
  assign m0_valid = ((state_q == ctrl_mem_read) && !sent_q) || (state_q == ctrl_mem_write);
  assign m0_we    = (state_q == ctrl_mem_write);
  assign m0_addr  = req_addr_q;
  assign m0_wdata = req_wdata_q;

  // CPU response, hit path two cycles after acceptance
  assign cpu_rvalid = hit_rd || rd_done;
  assign cpu_rdata  = hit_rd ? st_rdata : m0_rdata;
  assign cpu_hit    = hit_rd;

endmodule

// File: design/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  // CPU-side controller
  typedef enum logic [2:0] {
    ctrl_idle,        // Waiting for a CPU or invalidation request
    ctrl_lookup,      // Store read for a CPU request
    ctrl_compare,     // Store answer is valid here
    ctrl_mem_read,    // Miss or bypass read on the memory bus
    ctrl_fill,        // Write fetched word, tag and used bit
    ctrl_mem_write,   // Write-through to memory
    ctrl_invalidate   // Store read for a DMA invalidation
  } ctrl_state_t;

  // DMA master
  typedef enum logic [1:0] {
    dma_idle,         // Ready for a DMA cycle
    dma_snoop,        // Invalidation handshake before a write
    dma_mem_req,      // Request held on the memory bus
    dma_mem_wait      // Read issued, waiting for data
  } dma_state_t;

  typedef enum logic {cpu_side, dma_side} mem_owner_t;  // Memory bus masters

endpackage

// File: design/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Word address seen by the CPU and the DMA master
`define CACHE_ADDR_W  24

// Direct mapped split of the word address
`define CACHE_INDEX_W 11  // Low address bits select the entry
`define CACHE_TAG_W   13  // High address bits stored as the page tag

// One 16-bit word per entry
`define CACHE_DATA_W  16

// Number of entries, also the length of a clear sweep in cycles
`define CACHE_ENTRIES 2048

`endif

// File: design/cache_store.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_store
  import cache_types_pkg::*;
(
  input  logic         sysclk,
  input  logic         rst_n,        // Synchronous, starts a sweep
  input  logic         st_en,        // Access this cycle
  input  logic         st_we_data,   // Write the data word
  input  logic         st_set_used,  // Fill, writes tag and sets used
  input  logic         st_clr_used,  // Invalidate the entry
  input  cache_index_t st_index,
  input  cache_tag_t   st_tag,
  input  data_word_t   st_wdata,
  input  logic         clear_req,    // Start a bulk clear
  output data_word_t   st_rdata,     // Registered data, one cycle after st_en
  output logic         st_hit,       // Stored tag matches and entry used
  output logic         clear_busy    // Sweep running
);

  data_word_t data_mem [`CACHE_ENTRIES];  // Cache data words
  cache_tag_t tag_mem  [`CACHE_ENTRIES];  // Stored page-number tags
  logic       used_mem [`CACHE_ENTRIES];  // One used bit per entry

  data_word_t   rdata_q;      // Read data register
  cache_tag_t   tag_q;        // Tag read from the array
  cache_tag_t   req_tag_q;    // Tag of the request being compared
  logic         used_q;       // Used bit read from the array

  logic         clr_active;   // Sweep in progress
  cache_index_t clr_idx;      // Entry cleared this cycle

  // Sweep counter, one used bit per cycle
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      clr_active <= 1'b1;  // Every reset clears the whole cache
      clr_idx    <= '0;
    end else if (clr_active) begin
      clr_idx <= clr_idx + 1'b1;
      if (clr_idx == {`CACHE_INDEX_W{1'b1}}) begin
        clr_active <= 1'b0;  // Last entry done
      end
    end else if (clear_req) begin
      clr_active <= 1'b1;
      clr_idx    <= '0;
    end
  end

  // Used bits, the sweep wins over any access
  always_ff @(posedge sysclk) begin
    if (clr_active) begin
      used_mem[clr_idx] <= 1'b0;
    end else if (st_en && st_set_used) begin
      used_mem[st_index] <= 1'b1;  // Entry now valid
    end else if (st_en && st_clr_used) begin
      used_mem[st_index] <= 1'b0;  // Snooped DMA write
    end
  end

  // Data and tag arrays
  always_ff @(posedge sysclk) begin
    if (st_en && st_we_data) begin
      data_mem[st_index] <= st_wdata;  // Fill or write hit
    end
    if (st_en && st_set_used) begin
      tag_mem[st_index] <= st_tag;  // Tag only changes on fill
    end
  end

  // Read port, old contents on a same-cycle write
  always_ff @(posedge sysclk) begin
    if (st_en) begin
      rdata_q   <= data_mem[st_index];
      tag_q     <= tag_mem[st_index];
      used_q    <= used_mem[st_index];
      req_tag_q <= st_tag;  // Compared against the stored tag next cycle
    end
  end

  assign st_rdata   = rdata_q;
  assign st_hit     = used_q && (tag_q == req_tag_q);  // Held until the next access
  assign clear_busy = clr_active;

endmodule

// File: design/cache_subsystem_top.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_subsystem_top
  import cache_types_pkg::*;
(
  input  logic       sysclk,
  input  logic       rst_n,
  input  logic       cache_enable,
  input  logic       clear_req,
  output logic       clear_busy,
  // CPU
  input  logic       cpu_valid,
  output logic       cpu_ready,
  input  logic       cpu_we,
  input  word_addr_t cpu_addr,
  input  data_word_t cpu_wdata,
  output logic       cpu_rvalid,
  output data_word_t cpu_rdata,
  output logic       cpu_hit,
  // DMA
  input  logic       dma_valid,
  output logic       dma_ready,
  input  logic       dma_we,
  input  word_addr_t dma_addr,
  input  data_word_t dma_wdata,
  output logic       dma_rvalid,
  output data_word_t dma_rdata,
  // Main memory
  output logic       mem_valid,
  input  logic       mem_ready,
  output logic       mem_we,
  output word_addr_t mem_addr,
  output data_word_t mem_wdata,
  input  logic       mem_rvalid,
  input  data_word_t mem_rdata
);

  logic         st_en, st_we_data, st_set_used, st_clr_used, st_hit;
  cache_index_t st_index;  // Address bits 10 to 0
  cache_tag_t   st_tag;    // Address bits 23 to 11
  data_word_t   st_wdata, st_rdata;

  logic         inv_valid, inv_ready;
  word_addr_t   inv_addr;

  logic         m0_valid, m0_ready, m0_we, m0_rvalid;
  word_addr_t   m0_addr;
  data_word_t   m0_wdata, m0_rdata;
  logic         m1_valid, m1_ready, m1_we, m1_rvalid;
  word_addr_t   m1_addr;
  data_word_t   m1_wdata, m1_rdata;

  cache_store u_store (.*);        // Data, tags, used bits and sweep
  cache_ctrl u_ctrl (.*);          // CPU lookup, fill and write-through
  dma_snoop_port u_dma (.*);       // DMA master with snoop invalidation
  mem_arbiter u_arb (.*);          // Shares the memory bus

endmodule

// File: design/cache_types_pkg.sv
`include "cache_defs.svh"

package cache_types_pkg;

  // Full word address on the CPU, DMA and memory ports
  typedef logic [`CACHE_ADDR_W-1:0] word_addr_t;

  // Address bits 10 to 0, picks the cache entry
  typedef logic [`CACHE_INDEX_W-1:0] cache_index_t;

  // Address bits 23 to 11, kept per entry and compared on lookup
  typedef logic [`CACHE_TAG_W-1:0] cache_tag_t;

  // Data word in the cache and on every bus
  typedef logic [`CACHE_DATA_W-1:0] data_word_t;

endpackage

// File: design/dma_snoop_port.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module dma_snoop_port
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic       sysclk,
  input  logic       rst_n,
  input  logic       dma_valid,
  output logic       dma_ready,
  input  logic       dma_we,
  input  word_addr_t dma_addr,
  input  data_word_t dma_wdata,
  output logic       dma_rvalid,
  output data_word_t dma_rdata,
  output logic       inv_valid,   // Invalidate before the write
  input  logic       inv_ready,
  output word_addr_t inv_addr,
  output logic       m1_valid,
  input  logic       m1_ready,
  output logic       m1_we,
  output word_addr_t m1_addr,
  output data_word_t m1_wdata,
  input  logic       m1_rvalid,
  input  data_word_t m1_rdata
);

  dma_state_t state_q;
  logic       armed_q;  // Set once the first sweep after reset is over
  word_addr_t addr_q;
  data_word_t wdata_q;
  logic       we_q;

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      state_q <= dma_idle;
      armed_q <= 1'b0;
    end else begin
      if (inv_ready) armed_q <= 1'b1;  // Controller free, sweep finished
      case (state_q)
        dma_idle:     if (dma_valid && dma_ready) state_q <= dma_we ? dma_snoop : dma_mem_req;
        dma_snoop:    if (inv_ready) state_q <= dma_mem_req;
        dma_mem_req:  if (m1_ready) state_q <= we_q ? dma_idle : dma_mem_wait;
        dma_mem_wait: if (m1_rvalid) state_q <= dma_idle;
        default:      state_q <= dma_idle;
      endcase
    end
  end

  always_ff @(posedge sysclk) begin
    if (dma_valid && dma_ready) begin
      addr_q  <= dma_addr;
      wdata_q <= dma_wdata;
      we_q    <= dma_we;
    end
  end

  assign dma_ready  = (state_q == dma_idle) && armed_q;
  assign inv_valid  = (state_q == dma_snoop);
  assign inv_addr   = addr_q;
  assign m1_valid   = (state_q == dma_mem_req);
  assign m1_we      = we_q;
  assign m1_addr    = addr_q;
  assign m1_wdata   = wdata_q;
  assign dma_rvalid = (state_q == dma_mem_wait) && m1_rvalid;
  assign dma_rdata  = dma_rvalid ? m1_rdata : {`CACHE_DATA_W{1'b0}};

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module mem_arbiter
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
(
  input  logic       sysclk,
  input  logic       rst_n,
  input  logic       m0_valid,   // CPU-side controller
  output logic       m0_ready,
  input  logic       m0_we,
  input  word_addr_t m0_addr,
  input  data_word_t m0_wdata,
  output logic       m0_rvalid,
  output data_word_t m0_rdata,
  input  logic       m1_valid,   // DMA port
  output logic       m1_ready,
  input  logic       m1_we,
  input  word_addr_t m1_addr,
  input  data_word_t m1_wdata,
  output logic       m1_rvalid,
  output data_word_t m1_rdata,
  output logic       mem_valid,  // Main-memory bus
  input  logic       mem_ready,
  output logic       mem_we,
  output word_addr_t mem_addr,
  output data_word_t mem_wdata,
  input  logic       mem_rvalid,
  input  data_word_t mem_rdata
);

  mem_owner_t owner_q;  // Master holding the bus
  mem_owner_t last_q;   // Last master served
  mem_owner_t pick;     // Round-robin choice
  mem_owner_t sel;      // Master driving the bus this cycle
  logic       pend_q;   // Request shown but not yet taken
  logic       rd_q;     // Read outstanding

  always_comb begin
    if (m0_valid && m1_valid) pick = (last_q == cpu_side) ? dma_side : cpu_side;
    else if (m1_valid)        pick = dma_side;
    else                      pick = cpu_side;
  end

  assign sel = (pend_q || rd_q) ? owner_q : pick;  // Grant fixed until completion

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      owner_q <= cpu_side;
      last_q  <= dma_side;  // CPU side goes first
      pend_q  <= 1'b0;
      rd_q    <= 1'b0;
    end else if (rd_q) begin
      if (mem_rvalid) rd_q <= 1'b0;
    end else if (mem_valid) begin
      owner_q <= sel;
      if (mem_ready) begin
        last_q <= sel;
        pend_q <= 1'b0;
        rd_q   <= !mem_we;  // Writes end on acceptance
      end else begin
        pend_q <= 1'b1;
      end
    end
  end

  // Request multiplexer, nothing new while a read is open
  assign mem_valid = !rd_q && ((sel == cpu_side) ? m0_valid : m1_valid);
  assign mem_we    = (sel == cpu_side) ? m0_we : m1_we;
  assign mem_addr  = (sel == cpu_side) ? m0_addr : m1_addr;
  assign mem_wdata = (sel == cpu_side) ? m0_wdata : m1_wdata;

  assign m0_ready  = !rd_q && (sel == cpu_side) && mem_ready;
  assign m1_ready  = !rd_q && (sel == dma_side) && mem_ready;

  // Response back to the owner
  assign m0_rvalid = rd_q && (owner_q == cpu_side) && mem_rvalid;
  assign m1_rvalid = rd_q && (owner_q == dma_side) && mem_rvalid;
  assign m0_rdata  = m0_rvalid ? mem_rdata : {`CACHE_DATA_W{1'b0}};
  assign m1_rdata  = m1_rvalid ? mem_rdata : {`CACHE_DATA_W{1'b0}};

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cache subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module cache_tb -f vlog.f -o sim_cache_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_cache_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// File: verification/cache_tb.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb
  import cache_types_pkg::*;
  import cache_ctrl_pkg::*;
();

  localparam int n_random = 200;            // Accesses in the mixed traffic test
  localparam int n_access = 40 + n_random;  // Every access of the run
  // Two sweeps plus four cycles per access, four times over
  localparam int timeout_cycles = (2 * `CACHE_ENTRIES + 4 * n_access) * 4;

  logic       sysclk, rst_n, cache_enable, clear_req, clear_busy;
  logic       cpu_valid, cpu_ready, cpu_we, cpu_rvalid, cpu_hit;
  word_addr_t cpu_addr;
  data_word_t cpu_wdata, cpu_rdata;
  logic       dma_valid, dma_ready, dma_we, dma_rvalid;
  word_addr_t dma_addr;
  data_word_t dma_wdata, dma_rdata;
  logic       mem_valid, mem_ready, mem_we, mem_rvalid;
  word_addr_t mem_addr;
  data_word_t mem_wdata, mem_rdata;

  integer     seed;                          // Random state for bus timing and traffic
  int         errors, checks, tests, err_mark;
  int         lat;                           // Edges from CPU acceptance to completion
  data_word_t mem_model [word_addr_t];       // Main memory, written words only
  word_addr_t rd_addr;                       // Bus read in flight
  int         rd_cnt;                        // Cycles until its data
  logic       take;

  data_word_t ref_mem [word_addr_t];         // Expected memory contents
  data_word_t ref_data [`CACHE_ENTRIES];     // Shadow cache words
  cache_tag_t ref_tag [`CACHE_ENTRIES];      // Shadow tags
  logic       ref_used [`CACHE_ENTRIES];     // Shadow used bits
  logic [`CACHE_DATA_W:0] cpu_exp_q [$];     // {hit, data} per CPU read
  data_word_t dma_exp_q [$];
  logic [`CACHE_DATA_W:0] exp_rd;

  cache_subsystem_top u_dut (.*);

  always #2 sysclk = ~sysclk;  // 4 ns period

  // Unwritten words read back a pattern of the whole address
  function automatic data_word_t init_word(input word_addr_t addr);
    return addr[15:0] ^ {addr[23:16], addr[23:16]} ^ 16'h5a3c;
  endfunction

  function automatic data_word_t bus_word(input word_addr_t addr);
    return mem_model.exists(addr) ? mem_model[addr] : init_word(addr);
  endfunction

  function automatic data_word_t ref_word(input word_addr_t addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : init_word(addr);
  endfunction

  function automatic logic ref_hit(input word_addr_t addr);
    cache_index_t idx;
    idx = addr[`CACHE_INDEX_W-1:0];
    return ref_used[idx] && (ref_tag[idx] == addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W]);
  endfunction

  // Expected {hit, data} of a CPU read, cached word only when enabled
  function automatic logic [`CACHE_DATA_W:0] predict_read(input word_addr_t addr, input logic en);
    if (en && ref_hit(addr)) return {1'b1, ref_data[addr[`CACHE_INDEX_W-1:0]]};
    else return {1'b0, ref_word(addr)};
  endfunction

  function automatic void apply_cpu(input logic we, input word_addr_t addr,
                                    input data_word_t wdata, input logic en);
    cache_index_t idx;
    logic         hit;
    idx = addr[`CACHE_INDEX_W-1:0];
    hit = ref_hit(addr);
    if (we) begin
      ref_mem[addr] = wdata;                 // Always written through
      if (en && hit) ref_data[idx] = wdata;  // No write-allocate
    end else if (en && !hit) begin
      ref_data[idx] = ref_word(addr);        // Fill on miss
      ref_tag[idx]  = addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
      ref_used[idx] = 1'b1;
    end
  endfunction

  function automatic void apply_dma_write(input word_addr_t addr, input data_word_t wdata);
    if (ref_hit(addr)) ref_used[addr[`CACHE_INDEX_W-1:0]] = 1'b0;  // Snoop invalidation
    ref_mem[addr] = wdata;
  endfunction

  function automatic void ref_clear();
    for (int i = 0; i < `CACHE_ENTRIES; i++) ref_used[i] = 1'b0;
  endfunction

  task automatic check_data(input string name, input data_word_t got, input data_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0.1f ns: %s got %h expected %h", $realtime, name, got, exp);
    end
  endtask

  task automatic check_hit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0.1f ns: %s got %b expected %b", $realtime, name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0.1f ns: %s got %0d expected %0d", $realtime, name, got, exp);
    end
  endtask

  // Read responses checked in arrival order
  always @(posedge sysclk) begin
    if (cpu_rvalid) begin
      if (cpu_exp_q.size() == 0) begin
        errors++;
        $display("CPU read data at %0.1f ns with no CPU read outstanding", $realtime);
      end else begin
        exp_rd = cpu_exp_q.pop_front();
        check_data("cpu_rdata", cpu_rdata, exp_rd[`CACHE_DATA_W-1:0]);
        check_hit("cpu_hit", cpu_hit, exp_rd[`CACHE_DATA_W]);
      end
    end
    if (dma_rvalid) begin
      if (dma_exp_q.size() == 0) begin
        errors++;
        $display("DMA read data at %0.1f ns with no DMA read outstanding", $realtime);
      end else begin
        check_data("dma_rdata", dma_rdata, dma_exp_q.pop_front());
      end
    end
  end

  // Main memory, bus sampled at the edge and answered half a nanosecond later
  always begin
    @(posedge sysclk);
    take = mem_valid && mem_ready;
    if (take && mem_we) mem_model[mem_addr] = mem_wdata;
    if (take && !mem_we) begin
      rd_addr = mem_addr;
      rd_cnt  = 1 + ($unsigned($random(seed)) % 4);  // 1 to 4 cycles
    end
    #0.5;
    mem_rvalid = 1'b0;
    if (rd_cnt > 0) begin
      rd_cnt--;
      if (rd_cnt == 0) begin
        mem_rvalid = 1'b1;
        mem_rdata  = bus_word(rd_addr);
      end
    end
    mem_ready = ($unsigned($random(seed)) % 4) != 0;  // Low about one cycle in four
  end

  task automatic cpu_access(input logic we, input word_addr_t addr, input data_word_t wdata,
                            output int cycles);
    cycles = 0;
    @(posedge sysclk);
    #0.5;
    if (!we) cpu_exp_q.push_back(predict_read(addr, cache_enable));
    cpu_valid = 1'b1;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    do @(posedge sysclk); while (!cpu_ready);  // Accepted at this edge
    #0.5;
    cpu_valid = 1'b0;
    apply_cpu(we, addr, wdata, cache_enable);
    do begin
      @(posedge sysclk);
      cycles++;
    end while (we ? !cpu_ready : !cpu_rvalid);
    #0.5;
  endtask

  task automatic dma_access(input logic we, input word_addr_t addr, input data_word_t wdata);
    @(posedge sysclk);
    #0.5;
    if (!we) dma_exp_q.push_back(ref_word(addr));
    dma_valid = 1'b1;
    dma_we    = we;
    dma_addr  = addr;
    dma_wdata = wdata;
    do @(posedge sysclk); while (!dma_ready);
    #0.5;
    dma_valid = 1'b0;
    if (we) apply_dma_write(addr, wdata);
    do @(posedge sysclk); while (we ? !dma_ready : !dma_rvalid);
    #0.5;
  endtask

  // CPU tags 0 to 3 and DMA tags 4 to 7 on shared indices
  task automatic cpu_random();
    int unsigned r;
    r = $random(seed);
    cpu_access(r[8], {11'd0, r[1:0], 8'd0, r[4:2]}, r[31:16], lat);
  endtask

  task automatic dma_random();
    int unsigned r;
    r = $random(seed);
    dma_access(r[8], {10'd0, 1'b1, r[1:0], 8'd0, r[4:2]}, r[31:16]);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %-28s %s, %0d errors", name,
             (errors == err_mark) ? "passed" : "failed", errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    seed = 32'hb111bafe;
    sysclk = 1'b0;
    rst_n = 1'b0;
    cache_enable = 1'b1;
    {clear_req, cpu_valid, cpu_we, dma_valid, dma_we, mem_ready, mem_rvalid} = '0;
    {cpu_addr, dma_addr, cpu_wdata, dma_wdata, mem_rdata} = '0;
    {errors, checks, tests, err_mark, rd_cnt} = '0;
    ref_clear();  // Reset sweep empties the cache
    repeat (4) @(posedge sysclk);
    #0.5;
    rst_n = 1'b1;

    cpu_access(1'b0, 24'h012345, '0, lat);
    cpu_access(1'b0, 24'h012345, '0, lat);
    check_cycles("read hit latency", lat, 2);
    finish_test("1 read miss then hit");

    cpu_access(1'b1, 24'h012345, 16'hbeef, lat);  // Cached, word updated
    check_data("mem_model", bus_word(24'h012345), 16'hbeef);
    cpu_access(1'b0, 24'h012345, '0, lat);
    cpu_access(1'b1, 24'h0a0777, 16'h1234, lat);  // Uncached, stays a miss
    check_data("mem_model", bus_word(24'h0a0777), 16'h1234);
    cpu_access(1'b0, 24'h0a0777, '0, lat);
    finish_test("2 write-through");

    cpu_access(1'b0, 24'h012b45, '0, lat);  // Same index 0x345, other tag
    cpu_access(1'b0, 24'h012345, '0, lat);
    cpu_access(1'b0, 24'h012345, '0, lat);
    finish_test("3 same index replacement");

    dma_access(1'b1, 24'h012345, 16'hd00d);
    cpu_access(1'b0, 24'h012345, '0, lat);
    dma_access(1'b0, 24'h0a0777, '0);
    dma_access(1'b0, 24'h7f0001, '0);
    finish_test("4 DMA snoop invalidation");

    clear_req = 1'b1;
    @(posedge sysclk);
    #0.5;
    clear_req = 1'b0;
    @(posedge sysclk);
    check_hit("clear_busy", clear_busy, 1'b1);
    ref_clear();
    cpu_access(1'b0, 24'h012345, '0, lat);
    cpu_access(1'b0, 24'h0a0777, '0, lat);
    cache_enable = 1'b0;  // Bypass, both reads go to memory
    cpu_access(1'b0, 24'h012345, '0, lat);
    cpu_access(1'b0, 24'h012345, '0, lat);
    cache_enable = 1'b1;
    finish_test("5 clear and cache disable");

    fork
      repeat (n_random / 2) cpu_random();
      repeat (n_random / 2) dma_random();
    join
    finish_test("6 random mixed traffic");

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge sysclk);
    $display("Run timed out after %0d cycles, a handshake never completed", timeout_cycles);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+design
design/cache_types_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_store.sv
design/cache_ctrl.sv
design/dma_snoop_port.sv
design/mem_arbiter.sv
design/cache_subsystem_top.sv
verification/cache_tb.sv
